/* build.f */
+incdir+tests
hw/soc_pkg.sv
hw/hs_axi_master.sv
hw/axi_interconnect.sv
hw/axi_ram.sv
hw/axi_uart_tx.sv
hw/soc_fabric_top.sv
tests/tb_soc_fabric_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the fabric testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/10ps \
	-f build.f --top-module tb_soc_fabric_top -o tb_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^NO ERRORS$" "$LOG"; then
	echo "Simulation passed"
	exit 0
else
	echo "Simulation failed, see $LOG"
	exit 1
fi

/* tests/tb_tests.svh */
// Put one request on a port, 1 is data and 0 is instr
task automatic drive_port(input bit port, input soc_pkg::hs_req_t req);
	if (port)
		data_req = req;
	else
		instr_req = req;
endtask

// Called on a falling edge, returns on the falling edge that shows ready
task automatic send_request(input bit port, input soc_pkg::hs_req_t req,
	output soc_pkg::hs_rsp_t rsp);
	int waited;
	logic seen;
	drive_port(port, req);
	waited = 0;
	seen = 1'b0;
	rsp = '0;
	while (!seen && waited < HS_TIMEOUT) begin
		@(negedge clk);
		waited++;
		rsp = port ? data_rsp : instr_rsp;
		seen = (rsp.ready === 1'b1);
	end
	drive_port(port, '0); // Dropped in the ready cycle
	if (!seen) begin
		$display("%s port got no ready within %0d cycles", port ? "data" : "instr", HS_TIMEOUT);
		error_count++;
	end
endtask

task automatic hs_read(input bit port, input soc_pkg::addr_t addr,
	output soc_pkg::data_t rdata, output logic err);
	soc_pkg::hs_req_t req;
	soc_pkg::hs_rsp_t rsp;
	req = '0;
	req.read = 1'b1;
	req.addr = addr;
	send_request(port, req, rsp);
	rdata = rsp.rdata;
	err = rsp.err;
endtask

task automatic hs_write(input bit port, input soc_pkg::addr_t addr, input soc_pkg::data_t wdata,
	input soc_pkg::strb_t strb, output logic err);
	soc_pkg::hs_req_t req;
	soc_pkg::hs_rsp_t rsp;
	req = '0;
	req.write = 1'b1;
	req.addr = addr;
	req.wdata = wdata;
	req.strb = strb;
	send_request(port, req, rsp);
	err = rsp.err;
endtask

// Strobed bytes come from new_word, the rest stay
function automatic soc_pkg::data_t merge_bytes(input soc_pkg::data_t old_word,
	input soc_pkg::data_t new_word, input soc_pkg::strb_t strb);
	soc_pkg::data_t mask;
	mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
	return (old_word & ~mask) | (new_word & mask);
endfunction

task automatic report_test(input string name, input int start_errors);
	tests_run++;
	if (error_count == start_errors) begin
		$display("Test %s: pass", name);
	end else begin
		tests_failed++;
		$display("Test %s: fail, %0d bad checks", name, error_count - start_errors);
	end
endtask

task test_ram_word();
	int start_errors;
	soc_pkg::addr_t addr;
	soc_pkg::data_t wdata;
	soc_pkg::data_t rdata;
	logic err;
	start_errors = error_count;
	addr = ($urandom() & 32'h3ff) << 2; // Random word in region 0
	wdata = $urandom();
	hs_write(1'b1, addr, wdata, 4'hf, err);
	if (err !== 1'b0) begin
		$display("FAIL ram_word: data err = 0x%h, expected 0x0", err);
		error_count++;
	end
	for (int port = 0; port < 2; port++) begin
		hs_read(port[0], addr, rdata, err);
		if (rdata !== wdata || err !== 1'b0) begin
			$display("FAIL ram_word: %s rdata/err = 0x%08h/0x%h, expected 0x%08h/0x0",
				port[0] ? "data" : "instr", rdata, err, wdata);
			error_count++;
		end
	end
	report_test("ram_word", start_errors);
endtask

task test_byte_strobes();
	int start_errors;
	soc_pkg::addr_t addr;
	soc_pkg::data_t first;
	soc_pkg::data_t second;
	soc_pkg::data_t rdata;
	logic err;
	start_errors = error_count;
	addr = ($urandom() & 32'h3ff) << 2;
	first = $urandom();
	second = $urandom();
	hs_write(1'b1, addr, first, 4'hf, err);
	hs_write(1'b1, addr, second, 4'b0101, err); // Bytes 0 and 2 only
	hs_read(1'b1, addr, rdata, err);
	if (rdata !== merge_bytes(first, second, 4'b0101)) begin
		$display("FAIL byte_strobes: data rdata = 0x%08h, expected 0x%08h",
			rdata, merge_bytes(first, second, 4'b0101));
		error_count++;
	end
	report_test("byte_strobes", start_errors);
endtask

task test_unmapped_region();
	int start_errors;
	soc_pkg::addr_t addr;
	soc_pkg::data_t rdata;
	logic err;
	start_errors = error_count;
	addr = soc_pkg::addr_t'(5) << soc_pkg::REGION_LSB;
	hs_read(1'b1, addr, rdata, err);
	if (err !== 1'b1 || rdata !== 32'h0) begin
		$display("FAIL unmapped: read err/rdata = 0x%h/0x%08h, expected 0x1/0x00000000",
			err, rdata);
		error_count++;
	end
	hs_write(1'b1, addr, $urandom(), 4'hf, err);
	if (err !== 1'b1) begin
		$display("FAIL unmapped: write err = 0x%h, expected 0x1", err);
		error_count++;
	end
	report_test("unmapped_region", start_errors);
endtask

task test_arbitration();
	int start_errors;
	soc_pkg::addr_t addr_i;
	soc_pkg::addr_t addr_d;
	soc_pkg::data_t data_i;
	soc_pkg::data_t data_d;
	soc_pkg::data_t rdata;
	logic err_i;
	logic err_d;
	start_errors = error_count;
	addr_i = ($urandom() & 32'h3ff) << 2;
	addr_d = addr_i ^ 32'h4; // Neighbouring word
	data_i = $urandom();
	data_d = $urandom();
	fork // Same falling edge on both ports
		hs_write(1'b0, addr_i, data_i, 4'hf, err_i);
		hs_write(1'b1, addr_d, data_d, 4'hf, err_d);
	join
	if (err_i !== 1'b0 || err_d !== 1'b0) begin
		$display("FAIL arbitration: err instr/data = 0x%h/0x%h, expected 0x0/0x0", err_i, err_d);
		error_count++;
	end
	hs_read(1'b0, addr_i, rdata, err_i);
	if (rdata !== data_i) begin
		$display("FAIL arbitration: instr rdata = 0x%08h, expected 0x%08h", rdata, data_i);
		error_count++;
	end
	hs_read(1'b1, addr_d, rdata, err_d);
	if (rdata !== data_d) begin
		$display("FAIL arbitration: data rdata = 0x%08h, expected 0x%08h", rdata, data_d);
		error_count++;
	end
	report_test("arbitration", start_errors);
endtask

task test_uart_transmit();
	int start_errors;
	int waited;
	soc_pkg::addr_t base;
	logic [7:0] tx_byte;
	logic [7:0] rx_byte;
	soc_pkg::data_t status;
	logic err;
	start_errors = error_count;
	base = soc_pkg::addr_t'(soc_pkg::UART_REGION) << soc_pkg::REGION_LSB;
	tx_byte = 8'($urandom());
	rx_byte = '0;
	fork
		begin
			hs_write(1'b1, base, {24'h0, tx_byte}, 4'h1, err);
			if (err !== 1'b0) begin
				$display("FAIL uart_tx: write err = 0x%h, expected 0x0", err);
				error_count++;
			end
			hs_read(1'b1, base, status, err); // Frame still going out
			if (status !== 32'h1) begin
				$display("FAIL uart_tx: status rdata = 0x%08h, expected 0x00000001", status);
				error_count++;
			end
		end
		begin
			waited = 0;
			while (tx === 1'b1 && waited < FRAME_CYCLES) begin
				@(negedge clk);
				waited++;
			end
			if (tx !== 1'b0) begin
				$display("UART frame never started, tx_o stayed high");
				error_count++;
			end else begin
				repeat (soc_pkg::CLKS_PER_BIT / 2 - 1) @(negedge clk); // Mid start bit
				if (tx !== 1'b0) begin
					$display("FAIL uart_tx: start bit tx_o = 0x%h, expected 0x0", tx);
					error_count++;
				end
				for (int i = 0; i < 8; i++) begin
					repeat (soc_pkg::CLKS_PER_BIT) @(negedge clk);
					rx_byte[i] = tx; // LSB first
				end
				repeat (soc_pkg::CLKS_PER_BIT) @(negedge clk);
				if (tx !== 1'b1) begin
					$display("FAIL uart_tx: stop bit tx_o = 0x%h, expected 0x1", tx);
					error_count++;
				end
				if (rx_byte !== tx_byte) begin
					$display("FAIL uart_tx: tx_o byte = 0x%02h, expected 0x%02h", rx_byte, tx_byte);
					error_count++;
				end
			end
		end
	join
	repeat (soc_pkg::CLKS_PER_BIT) @(negedge clk); // Rest of stop bit
	hs_read(1'b1, base, status, err);
	if (status !== 32'h0) begin
		$display("FAIL uart_tx: status rdata = 0x%08h, expected 0x00000000", status);
		error_count++;
	end
	report_test("uart_transmit", start_errors);
endtask

task test_uart_bad_offset();
	int start_errors;
	int low_count;
	soc_pkg::addr_t base;
	logic err;
	start_errors = error_count;
	base = soc_pkg::addr_t'(soc_pkg::UART_REGION) << soc_pkg::REGION_LSB;
	hs_write(1'b1, base + 32'h4, 32'h0000_00a5, 4'hf, err);
	if (err !== 1'b1) begin
		$display("FAIL uart_bad_offset: write err = 0x%h, expected 0x1", err);
		error_count++;
	end
	low_count = 0;
	for (int i = 0; i < FRAME_CYCLES; i++) begin
		@(negedge clk);
		if (tx !== 1'b1) low_count++;
	end
	if (low_count != 0) begin
		$display("UART line left idle on a bad offset write, %0d low samples", low_count);
		error_count++;
	end
	report_test("uart_bad_offset", start_errors);
endtask

/* tests/tb_soc_fabric_top.sv */
`timescale 1ns/10ps

module tb_soc_fabric_top;

	localparam int CLK_PERIOD = 4;
	localparam int RESET_CYCLES = 5;
	localparam int HS_TIMEOUT = 100; // Cycles a port may wait for ready
	localparam int FRAME_CYCLES = 10 * soc_pkg::CLKS_PER_BIT; // Start, 8 data, stop
	// UART frames dominate the run, 20000 cycles leaves wide margin
	localparam int WATCHDOG_CYCLES = 250 * FRAME_CYCLES;
	localparam logic [31:0] SEED = 32'h78d25798;

	logic clk;
	logic rst_n;
	soc_pkg::hs_req_t instr_req;
	soc_pkg::hs_req_t data_req;
	soc_pkg::hs_rsp_t instr_rsp;
	soc_pkg::hs_rsp_t data_rsp;
	logic tx;

	int error_count;
	int tests_run;
	int tests_failed;
	int unsigned seed_ret;

	soc_fabric_top soc_fabric_top_inst (
		.clk_i(clk),
		.rst_n_i(rst_n),
		.instr_req_i(instr_req),
		.data_req_i(data_req),
		.instr_rsp_o(instr_rsp),
		.data_rsp_o(data_rsp),
		.tx_o(tx)
	);

	`include "tb_tests.svh"

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Watchdog
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Timeout after %0d cycles, a test never finished", WATCHDOG_CYCLES);
		$display("ERRORS FOUND");
		$finish;
	end

	initial begin
		instr_req = '0; // Both ports idle
		data_req = '0;
		rst_n = 1'b0;
		error_count = 0;
		tests_run = 0;
		tests_failed = 0;
		seed_ret = $urandom(SEED); // Only seeding call
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		// Idle state straight out of reset
		if (tx !== 1'b1) begin
			$display("FAIL reset: tx_o = 0x%h, expected 0x1", tx);
			error_count++;
		end
		if (instr_rsp.ready !== 1'b0 || data_rsp.ready !== 1'b0) begin
			$display("FAIL reset: ready instr/data = 0x%h/0x%h, expected 0x0/0x0",
				instr_rsp.ready, data_rsp.ready);
			error_count++;
		end
		@(negedge clk);

		test_ram_word();
		test_byte_strobes();
		test_unmapped_region();
		test_arbitration();
		test_uart_transmit();
		test_uart_bad_offset();

		$display("Tests run: %0d, tests failed: %0d, failed checks: %0d",
			tests_run, tests_failed, error_count);
		if (error_count == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

/* hw/soc_fabric_top.sv */
`timescale 1ns/10ps

module soc_fabric_top (
	input  logic              clk_i,
	input  logic              rst_n_i,
	// Core side ports
	input  soc_pkg::hs_req_t  instr_req_i,
	input  soc_pkg::hs_req_t  data_req_i,
	output soc_pkg::hs_rsp_t  instr_rsp_o,
	output soc_pkg::hs_rsp_t  data_rsp_o,
	// UART
	output logic              tx_o
);

	soc_pkg::axi_req_t instr_axi_req_s;
	soc_pkg::axi_rsp_t instr_axi_rsp_s;
	soc_pkg::axi_req_t data_axi_req_s;
	soc_pkg::axi_rsp_t data_axi_rsp_s;
	soc_pkg::axi_req_t ram_axi_req_s;
	soc_pkg::axi_rsp_t ram_axi_rsp_s;
	soc_pkg::axi_req_t uart_axi_req_s;
	soc_pkg::axi_rsp_t uart_axi_rsp_s;

	hs_axi_master inst_instr_axi_master (
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.hs_req_i(instr_req_i),
		.hs_rsp_o(instr_rsp_o),
		.axi_req_o(instr_axi_req_s),
		.axi_rsp_i(instr_axi_rsp_s)
	);

	hs_axi_master inst_data_axi_master (
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.hs_req_i(data_req_i),
		.hs_rsp_o(data_rsp_o),
		.axi_req_o(data_axi_req_s),
		.axi_rsp_i(data_axi_rsp_s)
	);

	// Instr is m0, data is m1
	axi_interconnect inst_axi_interconnect (
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.m0_req_i(instr_axi_req_s),
		.m1_req_i(data_axi_req_s),
		.m0_rsp_o(instr_axi_rsp_s),
		.m1_rsp_o(data_axi_rsp_s),
		.ram_req_o(ram_axi_req_s),
		.uart_req_o(uart_axi_req_s),
		.ram_rsp_i(ram_axi_rsp_s),
		.uart_rsp_i(uart_axi_rsp_s)
	);

	axi_ram inst_axi_ram (
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.axi_req_i(ram_axi_req_s),
		.axi_rsp_o(ram_axi_rsp_s)
	);

	axi_uart_tx inst_axi_uart_tx (
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.axi_req_i(uart_axi_req_s),
		.axi_rsp_o(uart_axi_rsp_s),
		.tx_o(tx_o)
	);

endmodule

/* hw/axi_uart_tx.sv */
`timescale 1ns/10ps

module axi_uart_tx (
	input  logic               clk_i,
	input  logic               rst_n_i,
	input  soc_pkg::axi_req_t  axi_req_i,
	output soc_pkg::axi_rsp_t  axi_rsp_o,
	output logic               tx_o
);

	soc_pkg::uart_state_e state_q;
	logic [soc_pkg::UART_CNT_W-1:0] cnt_q; // Clocks within the current bit
	logic [2:0] bit_idx_q;
	logic [7:0] shift_q; // LSB goes out first
	logic tx_q;
	logic start_q; // Byte taken, frame starts next cycle
	logic b_valid_q;
	soc_pkg::resp_t b_resp_q;
	logic r_valid_q;
	logic r_busy_q;

	logic busy;
	logic wr_go;
	logic ar_go;
	logic off_ok;
	logic bit_end;

	assign busy = (state_q != soc_pkg::TX_IDLE) | start_q;
	// AW and W taken together, only while the line is idle
	assign wr_go = axi_req_i.aw_valid & axi_req_i.w_valid & ~busy & ~b_valid_q;
	assign ar_go = axi_req_i.ar_valid & ~r_valid_q;
	assign off_ok = (axi_req_i.aw_addr[soc_pkg::REGION_LSB-1:0] ==
		soc_pkg::UART_TX_OFFSET[soc_pkg::REGION_LSB-1:0]);
	assign bit_end = (int'(cnt_q) == soc_pkg::CLKS_PER_BIT - 1);
	assign tx_o = tx_q;

	always_comb begin
		axi_rsp_o = '0;
		axi_rsp_o.aw_ready = wr_go;
		axi_rsp_o.w_ready = wr_go;
		axi_rsp_o.b_valid = b_valid_q;
		axi_rsp_o.b_resp = b_resp_q;
		axi_rsp_o.ar_ready = ~r_valid_q;
		axi_rsp_o.r_valid = r_valid_q;
		axi_rsp_o.r_data = soc_pkg::data_t'(r_busy_q); // Status bit 0 is busy
		axi_rsp_o.r_resp = soc_pkg::RESP_OKAY;
	end

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q <= soc_pkg::TX_IDLE;
			cnt_q <= '0;
			bit_idx_q <= '0;
			shift_q <= '0;
			tx_q <= 1'b1; // Line idles high
			start_q <= 1'b0;
			b_valid_q <= 1'b0;
			b_resp_q <= soc_pkg::RESP_OKAY;
			r_valid_q <= 1'b0;
			r_busy_q <= 1'b0;
		end else begin
			// Write response
			if (wr_go) begin
				b_valid_q <= 1'b1;
				b_resp_q <= off_ok ? soc_pkg::RESP_OKAY : soc_pkg::RESP_SLVERR;
				if (off_ok && axi_req_i.w_strb[0]) begin
					start_q <= 1'b1;
					shift_q <= axi_req_i.w_data[7:0];
				end
			end else if (b_valid_q && axi_req_i.b_ready) begin
				b_valid_q <= 1'b0;
			end

			// Status read, sampled at AR
			if (ar_go) begin
				r_valid_q <= 1'b1;
				r_busy_q <= busy;
			end else if (r_valid_q && axi_req_i.r_ready) begin
				r_valid_q <= 1'b0;
			end

			if (state_q == soc_pkg::TX_IDLE)
				cnt_q <= '0;
			else
				cnt_q <= bit_end ? '0 : cnt_q + 1'b1;

			case (state_q)
				soc_pkg::TX_IDLE: begin
					if (start_q) begin
						start_q <= 1'b0;
						tx_q <= 1'b0; // Start bit
						state_q <= soc_pkg::TX_START;
					end
				end
				soc_pkg::TX_START: begin
					if (bit_end) begin
						tx_q <= shift_q[0];
						bit_idx_q <= '0;
						state_q <= soc_pkg::TX_DATA;
					end
				end
				soc_pkg::TX_DATA: begin
					if (bit_end) begin
						if (bit_idx_q == 3'd7) begin
							tx_q <= 1'b1; // Stop bit
							state_q <= soc_pkg::TX_STOP;
						end else begin
							bit_idx_q <= bit_idx_q + 1'b1;
							shift_q <= shift_q >> 1;
							tx_q <= shift_q[1];
						end
					end
				end
				soc_pkg::TX_STOP: if (bit_end) state_q <= soc_pkg::TX_IDLE;
				default: state_q <= soc_pkg::TX_IDLE;
			endcase
		end
	end

	// Registered line must be back high whenever the FSM rests
	idle_high_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		state_q == soc_pkg::TX_IDLE |-> tx_o);

endmodule

/* hw/axi_ram.sv */
`timescale 1ns/10ps

module axi_ram (
	input  logic               clk_i,
	input  logic               rst_n_i,
	input  soc_pkg::axi_req_t  axi_req_i,
	output soc_pkg::axi_rsp_t  axi_rsp_o
);

	soc_pkg::data_t mem_q [soc_pkg::RAM_WORDS];

	logic aw_ok_q; // AW held, waiting for W
	logic w_ok_q; // W held, waiting for AW
	soc_pkg::addr_t awaddr_q;
	soc_pkg::data_t wdata_q;
	soc_pkg::strb_t wstrb_q;
	logic b_valid_q;
	logic r_valid_q;
	soc_pkg::data_t r_data_q;

	logic aw_hs;
	logic w_hs;
	logic ar_hs;
	logic wr_en;
	soc_pkg::addr_t wr_addr;
	soc_pkg::data_t wr_data;
	soc_pkg::strb_t wr_strb;
	logic [soc_pkg::RAM_IDX_W-1:0] wr_idx;
	logic [soc_pkg::RAM_IDX_W-1:0] rd_idx;

	// One write outstanding, no new AW or W while B is up
	assign aw_hs = axi_req_i.aw_valid & ~aw_ok_q & ~b_valid_q;
	assign w_hs = axi_req_i.w_valid & ~w_ok_q & ~b_valid_q;
	assign ar_hs = axi_req_i.ar_valid & ~r_valid_q;

	// Write once both halves are in, held or arriving now
	assign wr_en = (aw_ok_q | aw_hs) & (w_ok_q | w_hs);
	assign wr_addr = aw_ok_q ? awaddr_q : axi_req_i.aw_addr;
	assign wr_data = w_ok_q ? wdata_q : axi_req_i.w_data;
	assign wr_strb = w_ok_q ? wstrb_q : axi_req_i.w_strb;
	assign wr_idx = wr_addr[soc_pkg::RAM_IDX_W+1:2]; // Upper offset bits alias
	assign rd_idx = axi_req_i.ar_addr[soc_pkg::RAM_IDX_W+1:2];

	always_comb begin
		axi_rsp_o = '0;
		axi_rsp_o.aw_ready = ~aw_ok_q & ~b_valid_q;
		axi_rsp_o.w_ready = ~w_ok_q & ~b_valid_q;
		axi_rsp_o.b_valid = b_valid_q;
		axi_rsp_o.b_resp = soc_pkg::RESP_OKAY;
		axi_rsp_o.ar_ready = ~r_valid_q;
		axi_rsp_o.r_valid = r_valid_q;
		axi_rsp_o.r_data = r_data_q;
		axi_rsp_o.r_resp = soc_pkg::RESP_OKAY;
	end

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			aw_ok_q <= 1'b0;
			w_ok_q <= 1'b0;
			b_valid_q <= 1'b0;
			r_valid_q <= 1'b0;
		end else begin
			if (wr_en) begin
				aw_ok_q <= 1'b0;
				w_ok_q <= 1'b0;
				b_valid_q <= 1'b1; // B the cycle after acceptance
			end else begin
				if (aw_hs) aw_ok_q <= 1'b1;
				if (w_hs) w_ok_q <= 1'b1;
				if (b_valid_q && axi_req_i.b_ready) b_valid_q <= 1'b0;
			end
			if (ar_hs)
				r_valid_q <= 1'b1;
			else if (r_valid_q && axi_req_i.r_ready)
				r_valid_q <= 1'b0;
		end
	end

	// Holding registers and array
	always_ff @(posedge clk_i) begin
		if (aw_hs) awaddr_q <= axi_req_i.aw_addr;
		if (w_hs) begin
			wdata_q <= axi_req_i.w_data;
			wstrb_q <= axi_req_i.w_strb;
		end
		if (wr_en) begin
			for (int i = 0; i < soc_pkg::STRB_W; i++) begin
				if (wr_strb[i])
					mem_q[wr_idx][8*i +: 8] <= wr_data[8*i +: 8];
			end
		end
		if (ar_hs) r_data_q <= mem_q[rd_idx]; // Old data on a same cycle write
	end

endmodule

/* hw/axi_interconnect.sv */
`timescale 1ns/10ps

module axi_interconnect (
	input  logic               clk_i,
	input  logic               rst_n_i,
	// Masters, m0 instr and m1 data
	input  soc_pkg::axi_req_t  m0_req_i,
	input  soc_pkg::axi_req_t  m1_req_i,
	output soc_pkg::axi_rsp_t  m0_rsp_o,
	output soc_pkg::axi_rsp_t  m1_rsp_o,
	// Slaves
	output soc_pkg::axi_req_t  ram_req_o,
	output soc_pkg::axi_req_t  uart_req_o,
	input  soc_pkg::axi_rsp_t  ram_rsp_i,
	input  soc_pkg::axi_rsp_t  uart_rsp_i
);

	soc_pkg::ic_state_e state_q;
	logic gnt_q; // Granted master, kept as last served while idle
	logic sel_uart_q; // Routed slave, 0 is RAM
	logic err_a_q; // Address taken on the error path
	logic err_w_q; // Write data taken on the error path

	logic req0;
	logic req1;
	logic win;
	soc_pkg::axi_req_t win_req;
	soc_pkg::addr_t win_addr;
	soc_pkg::region_t win_region;
	logic win_mapped;
	soc_pkg::axi_req_t mst_req;
	soc_pkg::axi_rsp_t slv_rsp;
	soc_pkg::axi_rsp_t err_rsp;
	soc_pkg::axi_rsp_t route_rsp;
	logic xfer_done;

	assign req0 = m0_req_i.ar_valid | m0_req_i.aw_valid;
	assign req1 = m1_req_i.ar_valid | m1_req_i.aw_valid;

	// Round robin, the master not served last wins a tie
	assign win = (req0 && req1) ? ~gnt_q : req1;
	assign win_req = win ? m1_req_i : m0_req_i;
	assign win_addr = win_req.ar_valid ? win_req.ar_addr : win_req.aw_addr;
	assign win_region = win_addr[soc_pkg::ADDR_W-1:soc_pkg::REGION_LSB];
	assign win_mapped = (win_region == soc_pkg::RAM_REGION) ||
		(win_region == soc_pkg::UART_REGION);

	assign mst_req = gnt_q ? m1_req_i : m0_req_i;
	assign slv_rsp = sel_uart_q ? uart_rsp_i : ram_rsp_i;

	// Local DECERR slave, response one cycle after the last acceptance
	always_comb begin
		err_rsp = '0; // Read data stays 0
		if (state_q == soc_pkg::IC_ERR_R) begin
			err_rsp.ar_ready = ~err_a_q;
			err_rsp.r_valid = err_a_q;
			err_rsp.r_resp = soc_pkg::RESP_DECERR;
		end else if (state_q == soc_pkg::IC_ERR_B) begin
			err_rsp.aw_ready = ~err_a_q;
			err_rsp.w_ready = ~err_w_q;
			err_rsp.b_valid = err_a_q & err_w_q;
			err_rsp.b_resp = soc_pkg::RESP_DECERR;
		end
	end

	// Routing locked for the whole transaction
	always_comb begin
		ram_req_o = '0;
		uart_req_o = '0;
		m0_rsp_o = '0;
		m1_rsp_o = '0;
		case (state_q)
			soc_pkg::IC_READ, soc_pkg::IC_WRITE: begin
				if (sel_uart_q)
					uart_req_o = mst_req;
				else
					ram_req_o = mst_req;
				route_rsp = slv_rsp;
			end
			soc_pkg::IC_ERR_R, soc_pkg::IC_ERR_B: route_rsp = err_rsp;
			default: route_rsp = '0; // Idle, nobody sees a ready
		endcase
		if (gnt_q)
			m1_rsp_o = route_rsp;
		else
			m0_rsp_o = route_rsp;
	end

	// Grant ends on the R or B handshake
	assign xfer_done = (state_q == soc_pkg::IC_READ || state_q == soc_pkg::IC_ERR_R) ?
		(route_rsp.r_valid & mst_req.r_ready) : (route_rsp.b_valid & mst_req.b_ready);

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q <= soc_pkg::IC_IDLE;
			gnt_q <= 1'b1; // m0 wins the first tie
			sel_uart_q <= 1'b0;
			err_a_q <= 1'b0;
			err_w_q <= 1'b0;
		end else begin
			case (state_q)
				soc_pkg::IC_IDLE: begin
					if (req0 || req1) begin
						gnt_q <= win;
						sel_uart_q <= (win_region == soc_pkg::UART_REGION);
						if (win_mapped)
							state_q <= win_req.ar_valid ? soc_pkg::IC_READ : soc_pkg::IC_WRITE;
						else
							state_q <= win_req.ar_valid ? soc_pkg::IC_ERR_R : soc_pkg::IC_ERR_B;
					end
				end
				soc_pkg::IC_ERR_R, soc_pkg::IC_ERR_B: begin
					if ((mst_req.ar_valid && err_rsp.ar_ready) ||
						(mst_req.aw_valid && err_rsp.aw_ready))
						err_a_q <= 1'b1;
					if (mst_req.w_valid && err_rsp.w_ready)
						err_w_q <= 1'b1;
					if (xfer_done) begin
						err_a_q <= 1'b0;
						err_w_q <= 1'b0;
						state_q <= soc_pkg::IC_IDLE;
					end
				end
				default: if (xfer_done) state_q <= soc_pkg::IC_IDLE;
			endcase
		end
	end

	// Only one slave may be addressed at a time
	one_slave_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		!((ram_req_o.aw_valid || ram_req_o.w_valid || ram_req_o.ar_valid) &&
		(uart_req_o.aw_valid || uart_req_o.w_valid || uart_req_o.ar_valid)));

endmodule

/* hw/hs_axi_master.sv */
`timescale 1ns/10ps

module hs_axi_master (
	input  logic               clk_i,
	input  logic               rst_n_i,
	// Handshake port
	input  soc_pkg::hs_req_t   hs_req_i,
	output soc_pkg::hs_rsp_t   hs_rsp_o,
	// AXI-lite master side
	output soc_pkg::axi_req_t  axi_req_o,
	input  soc_pkg::axi_rsp_t  axi_rsp_i
);

	soc_pkg::mst_state_e state_q;
	soc_pkg::addr_t addr_q;
	soc_pkg::data_t wdata_q;
	soc_pkg::strb_t strb_q;
	soc_pkg::data_t rdata_q; // Captured on R handshake
	logic err_q;
	logic aw_done_q; // AW accepted, W may still be pending
	logic w_done_q;
	logic ar_hs;
	logic aw_hs;
	logic w_hs;

	assign ar_hs = axi_req_o.ar_valid & axi_rsp_i.ar_ready;
	assign aw_hs = axi_req_o.aw_valid & axi_rsp_i.aw_ready;
	assign w_hs = axi_req_o.w_valid & axi_rsp_i.w_ready;

	// Channel valids come straight from state, payload from the latched request
	always_comb begin
		axi_req_o = '0;
		axi_req_o.ar_addr = addr_q;
		axi_req_o.aw_addr = addr_q;
		axi_req_o.w_data = wdata_q;
		axi_req_o.w_strb = strb_q;
		axi_req_o.ar_valid = (state_q == soc_pkg::MST_AR);
		axi_req_o.r_ready = (state_q == soc_pkg::MST_R);
		axi_req_o.aw_valid = (state_q == soc_pkg::MST_AW_W) && !aw_done_q;
		axi_req_o.w_valid = (state_q == soc_pkg::MST_AW_W) && !w_done_q;
		axi_req_o.b_ready = (state_q == soc_pkg::MST_B);
	end

	assign hs_rsp_o = '{ready: (state_q == soc_pkg::MST_DONE), rdata: rdata_q, err: err_q};

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q <= soc_pkg::MST_IDLE;
			aw_done_q <= 1'b0;
			w_done_q <= 1'b0;
			err_q <= 1'b0;
		end else begin
			case (state_q)
				soc_pkg::MST_IDLE: begin
					aw_done_q <= 1'b0;
					w_done_q <= 1'b0;
					if (hs_req_i.read)
						state_q <= soc_pkg::MST_AR;
					else if (hs_req_i.write)
						state_q <= soc_pkg::MST_AW_W;
				end
				soc_pkg::MST_AR: if (ar_hs) state_q <= soc_pkg::MST_R;
				soc_pkg::MST_R: begin
					if (axi_rsp_i.r_valid) begin // r_ready is high here
						err_q <= (axi_rsp_i.r_resp != soc_pkg::RESP_OKAY);
						state_q <= soc_pkg::MST_DONE;
					end
				end
				soc_pkg::MST_AW_W: begin
					if (aw_hs) aw_done_q <= 1'b1;
					if (w_hs) w_done_q <= 1'b1;
					// Both may land in different cycles
					if ((aw_done_q || aw_hs) && (w_done_q || w_hs))
						state_q <= soc_pkg::MST_B;
				end
				soc_pkg::MST_B: begin
					if (axi_rsp_i.b_valid) begin
						err_q <= (axi_rsp_i.b_resp != soc_pkg::RESP_OKAY);
						state_q <= soc_pkg::MST_DONE;
					end
				end
				soc_pkg::MST_DONE: state_q <= soc_pkg::MST_IDLE; // Ready pulse cycle
				default: state_q <= soc_pkg::MST_IDLE;
			endcase
		end
	end

	// Request payload tracks the port while idle
	always_ff @(posedge clk_i) begin
		if (state_q == soc_pkg::MST_IDLE) begin
			addr_q <= hs_req_i.addr;
			wdata_q <= hs_req_i.wdata;
			strb_q <= hs_req_i.strb;
		end
		if (state_q == soc_pkg::MST_R && axi_rsp_i.r_valid)
			rdata_q <= axi_rsp_i.r_data;
	end

	// AR stays up with a stable address until the slave takes it
	ar_hold_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		axi_req_o.ar_valid && !axi_rsp_i.ar_ready
		|=> axi_req_o.ar_valid && $stable(axi_req_o.ar_addr));

	// Requester side rule
	rd_wr_excl_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		!(hs_req_i.read && hs_req_i.write));

endmodule

/* hw/soc_pkg.sv */
package soc_pkg;

	// Bus widths
	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;
	localparam int STRB_W = DATA_W / 8;
	localparam int REGION_LSB = 17; // Region field is addr[31:17]

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [DATA_W-1:0] data_t;
	typedef logic [STRB_W-1:0] strb_t;
	typedef logic [1:0] resp_t;
	typedef logic [ADDR_W-REGION_LSB-1:0] region_t;

	// Address map
	localparam region_t RAM_REGION = 15'd0;
	localparam region_t UART_REGION = 15'd2;
	localparam addr_t UART_TX_OFFSET = 32'h0; // Data register, the only writable one

	localparam int RAM_WORDS = 1024;
	localparam int RAM_IDX_W = $clog2(RAM_WORDS); // Word index from addr[11:2]

	localparam int CLKS_PER_BIT = 8;
	localparam int UART_CNT_W = $clog2(CLKS_PER_BIT);

	// AXI response codes
	localparam resp_t RESP_OKAY = 2'd0;
	localparam resp_t RESP_SLVERR = 2'd2;
	localparam resp_t RESP_DECERR = 2'd3;

	// Port side, read/write held until ready
	typedef struct packed {
		logic  read;
		logic  write;
		addr_t addr;
		data_t wdata;
		strb_t strb;
	} hs_req_t;

	typedef struct packed {
		logic  ready; // Single cycle pulse
		data_t rdata;
		logic  err;
	} hs_rsp_t;

	// Everything a master drives
	typedef struct packed {
		logic  aw_valid;
		addr_t aw_addr;
		logic  w_valid;
		data_t w_data;
		strb_t w_strb;
		logic  b_ready;
		logic  ar_valid;
		addr_t ar_addr;
		logic  r_ready;
	} axi_req_t;

	// Everything a slave drives
	typedef struct packed {
		logic  aw_ready;
		logic  w_ready;
		logic  b_valid;
		resp_t b_resp;
		logic  ar_ready;
		logic  r_valid;
		data_t r_data;
		resp_t r_resp;
	} axi_rsp_t;

	typedef enum logic [2:0] {
		MST_IDLE,
		MST_AR,
		MST_R,
		MST_AW_W,
		MST_B,
		MST_DONE
	} mst_state_e;

	typedef enum logic [2:0] {
		IC_IDLE,
		IC_READ,
		IC_WRITE,
		IC_ERR_R,
		IC_ERR_B
	} ic_state_e;

	typedef enum logic [1:0] {
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_STOP
	} uart_state_e;

endpackage
